//--- common/lsi_cfg.svh
// widths, register count, rom start address, alu op codes, control fields, host offsets
`ifndef LSI_CFG_SVH
`define LSI_CFG_SVH

`define LSI_WORD_W	16
`define LSI_BYTE_W	8
`define LSI_FLAG_W	4
`define LSI_PSW_W	8
`define LSI_CTRL_W	32
`define LSI_OP_W	4
`define LSI_REG_IDX_W	3
`define LSI_NREGS	8
`define LSI_AXI_ADDR_W	8
`define LSI_AXI_DATA_W	32
`define LSI_ROM_START	16'o100000	// pc after a rom start load

// ====================
// alu op codes
`define OP_ADD	4'd0
`define OP_SUB	4'd1
`define OP_INC	4'd2
`define OP_DEC	4'd3
`define OP_COM	4'd4
`define OP_NEG	4'd5
`define OP_MOV	4'd6
`define OP_CMP	4'd7
`define OP_BIC	4'd8
`define OP_BIS	4'd9
`define OP_XOR	4'd10
`define OP_ASL	4'd11
`define OP_ASR	4'd12
`define OP_ROL	4'd13
`define OP_ROR	4'd14
`define OP_SWAB	4'd15

// ====================
// micro-control word fields
`define CW_OP	3:0
`define CW_A_SEL	6:4	// 0 r[ra], 1 src, 2 dst, 3 pc, 4 psw
`define CW_B_SEL	8:7	// 0 src, 1 dst, 2 zero, 3 branch offset
`define CW_RA	11:9
`define CW_RD	14:12
`define CW_WR_REG	15
`define CW_WR_SRC	16
`define CW_WR_DST	17
`define CW_DBI_SRC	18	// wins over wr_src
`define CW_UPD_CC	19
`define CW_BYTE	20
`define CW_SET_OPC	21
`define CW_DST_PSW	22
`define CW_PC_ROM	23	// wins over an r7 write

// ====================
// host register offsets
`define HR_CTRL	8'h00
`define HR_DBI	8'h04
`define HR_STEP	8'h08	// write only
`define HR_STATUS	8'h0C	// taken in bit 8, psw below
`define HR_OPCODE	8'h10
`define HR_SRC	8'h14
`define HR_DST	8'h18
`define HR_ALUOUT	8'h1C
`define HR_R0	8'h20
`define HR_R7	8'h3C

`endif

//--- common/lsi_pkg.sv
// data path vector types and host read channel state enum
`include "lsi_cfg.svh"

package lsi_pkg;

	typedef logic [`LSI_WORD_W-1:0] word_t;
	typedef logic [`LSI_BYTE_W-1:0] byte_t;
	typedef logic [`LSI_FLAG_W-1:0] flags_t;	// n z v c
	typedef logic [`LSI_PSW_W-1:0] psw_t;	// priority, t, n z v c
	typedef logic [`LSI_CTRL_W-1:0] ctrl_t;
	typedef logic [`LSI_OP_W-1:0] alu_op_t;
	typedef logic [`LSI_REG_IDX_W-1:0] reg_idx_t;

	// host read channel
	typedef enum logic {
		RD_IDLE,
		RD_VALID
	} rd_state_t;

endpackage

//--- datapath/lsi_alu.sv
// two-input alu: word and byte modes, pdp-11 condition codes and flag update mask
`timescale 1ns/1ps
`include "lsi_cfg.svh"

module lsi_alu
	import lsi_pkg::*;
(
	input  word_t   a,
	input  word_t   b,
	input  alu_op_t op,
	input  logic    byte_mode,
	input  logic    c_in,
	output word_t   result,
	output flags_t  flags,
	output flags_t  mask
);

	word_t an;	// operands aligned so the sign sits in bit 15
	word_t bn;
	word_t unit;	// weight of the operand lsb after alignment
	word_t lane;	// bits owned by the operand
	word_t rn;
	word_t rm;
	word_t swapped;
	byte_t a_hi;
	logic [16:0] ext;	// add/sub with carry out
	logic n;
	logic z;
	logic v;
	logic c;

	// byte mode moves the low byte up so carries and signs land in bit 16/15
	assign an = byte_mode ? {a[7:0], 8'h00} : a;
	assign bn = byte_mode ? {b[7:0], 8'h00} : b;
	assign unit = byte_mode ? 16'h0100 : 16'h0001;
	assign lane = byte_mode ? 16'hff00 : 16'hffff;
	assign a_hi = a[15:8];
	assign swapped = {a[7:0], a[15:8]};

	always_comb begin
		ext = '0;
		rn = '0;
		v = 1'b0;
		c = 1'b0;
		mask = 4'b1111;
		case (op)
		`OP_ADD: begin
			ext = {1'b0, an} + {1'b0, bn};
			rn = ext[15:0];
			c = ext[16];
			v = (an[15] == bn[15]) && (rn[15] != an[15]);
		end
		`OP_SUB, `OP_CMP: begin
			ext = {1'b0, an} - {1'b0, bn};
			rn = ext[15:0];
			c = ext[16];	// borrow
			v = (an[15] != bn[15]) && (rn[15] != an[15]);
		end
		`OP_INC: begin
			rn = an + unit;
			v = (rn == 16'h8000);
			mask = 4'b1110;
		end
		`OP_DEC: begin
			rn = an - unit;
			v = (an == 16'h8000);
			mask = 4'b1110;
		end
		`OP_COM: begin
			rn = ~an;
			c = 1'b1;
		end
		`OP_NEG: begin
			rn = 16'h0000 - an;	// low byte stays zero in byte mode
			c = |rn;
			v = (rn == 16'h8000);
		end
		`OP_MOV: begin
			rn = bn;
			mask = 4'b1110;
		end
		`OP_BIC: begin
			rn = an & ~bn;
			mask = 4'b1110;
		end
		`OP_BIS: begin
			rn = an | bn;
			mask = 4'b1110;
		end
		`OP_XOR: begin
			rn = an ^ bn;
			mask = 4'b1110;
		end
		`OP_ASL, `OP_ROL: begin
			rn = (op == `OP_ROL && c_in) ? ((an << 1) | unit) : (an << 1);
			c = an[15];
			v = rn[15] ^ c;
		end
		`OP_ASR, `OP_ROR: begin
			rn = {(op == `OP_ROR) ? c_in : an[15], an[15:1]};
			c = a[0];	// operand lsb in both modes
			v = rn[15] ^ c;
		end
		default: rn = swapped;	// swab, flags from the low byte below
		endcase
	end

	assign rm = rn & lane;

	assign n = (op == `OP_SWAB) ? swapped[7] : rm[15];
	assign z = (op == `OP_SWAB) ? (swapped[7:0] == 8'h00) : (rm == 16'h0000);
	assign flags = {n, z, v, c};

	always_comb begin
		if (op == `OP_SWAB)
			result = swapped;
		else if (op == `OP_CMP)
			result = a;	// compare only sets flags
		else if (byte_mode)
			result = {a_hi, rm[15:8]};
		else
			result = rm;
	end

endmodule

//--- datapath/lsi_datapath.sv
// register file, src/dst/opcode latches, psw, operand muxes and branch condition
`timescale 1ns/1ps
`include "lsi_cfg.svh"

module lsi_datapath
	import lsi_pkg::*;
(
	input  logic     clk,
	input  logic     reset_n,
	input  logic     ce,
	input  ctrl_t    ctrl,
	input  word_t    dbi,
	input  reg_idx_t sel,
	output word_t    reg_data,
	output word_t    src,
	output word_t    dst,
	output word_t    opcode,
	output word_t    alu_out,
	output psw_t     psw,
	output logic     taken
);

	word_t regs [`LSI_NREGS];	// r7 is pc, r6 is sp
	word_t alu_a;
	word_t alu_b;
	flags_t alu_flags;
	flags_t alu_mask;
	flags_t cc;
	alu_op_t op;
	reg_idx_t ra;
	reg_idx_t rd;
	logic [2:0] cond;
	logic cond_hit;

	assign op = ctrl[`CW_OP];
	assign ra = ctrl[`CW_RA];
	assign rd = ctrl[`CW_RD];
	assign cc = psw[3:0];
	assign reg_data = regs[sel];

	// ====================
	// operand selection
	always_comb begin
		case (ctrl[`CW_A_SEL])
		3'd0: alu_a = regs[ra];
		3'd1: alu_a = src;
		3'd2: alu_a = dst;
		3'd3: alu_a = regs[7];
		3'd4: alu_a = {8'h00, psw};
		default: alu_a = '0;
		endcase
	end

	always_comb begin
		case (ctrl[`CW_B_SEL])
		2'd0: alu_b = src;
		2'd1: alu_b = dst;
		2'd2: alu_b = '0;
		default: alu_b = {{7{opcode[7]}}, opcode[7:0], 1'b0};	// branch offset in bytes
		endcase
	end

	lsi_alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.op(op),
		.byte_mode(ctrl[`CW_BYTE]),
		.c_in(cc[0]),
		.result(alu_out),
		.flags(alu_flags),
		.mask(alu_mask)
	);

	// ====================
	// state updates, one per ce
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < `LSI_NREGS; i++)
				regs[i] <= '0;
		end else if (ce) begin
			if (ctrl[`CW_WR_REG])
				regs[rd] <= alu_out;
			if (ctrl[`CW_PC_ROM])
				regs[7] <= `LSI_ROM_START;	// later assignment, so rom load wins
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			src <= '0;
			dst <= '0;
			opcode <= '0;
		end else if (ce) begin
			if (ctrl[`CW_DBI_SRC])
				src <= dbi;
			else if (ctrl[`CW_WR_SRC])
				src <= alu_out;
			if (ctrl[`CW_WR_DST])
				dst <= alu_out;
			if (ctrl[`CW_SET_OPC])
				opcode <= dbi;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			psw <= '0;
		end else if (ce && ctrl[`CW_UPD_CC]) begin
			if (ctrl[`CW_DST_PSW]) begin
				psw <= dst[7:0];	// priority, t and flags at once
			end else begin
				for (int i = 0; i < `LSI_FLAG_W; i++)
					if (alu_mask[i])
						psw[i] <= alu_flags[i];
			end
		end
	end

	// ====================
	// branch condition
	assign cond = {opcode[15], opcode[10:9]};

	always_comb begin
		case (cond)
		3'd0: cond_hit = 1'b1;
		3'd1: cond_hit = cc[2];	// z
		3'd2: cond_hit = cc[3] ^ cc[1];	// n^v
		3'd3: cond_hit = (cc[3] ^ cc[1]) | cc[2];
		3'd4: cond_hit = cc[3];
		3'd5: cond_hit = cc[0] | cc[2];
		3'd6: cond_hit = cc[1];
		default: cond_hit = cc[0];
		endcase
	end

	// bit 8 clear inverts the test
	assign taken = cond_hit ^ ~opcode[8];

endmodule

//--- src/lsi_host_regs.sv
// axi4-lite slave with ctrl/dbi registers, step enable and readback mux
`timescale 1ns/1ps
`include "lsi_cfg.svh"

module lsi_host_regs
	import lsi_pkg::*;
(
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic [`LSI_AXI_ADDR_W-1:0]    awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [`LSI_AXI_DATA_W-1:0]    wdata,
	input  logic [`LSI_AXI_DATA_W/8-1:0]  wstrb,	// ignored, whole-word writes
	input  logic                          wvalid,
	output logic                          wready,
	output logic [1:0]                    bresp,
	output logic                          bvalid,
	input  logic                          bready,
	input  logic [`LSI_AXI_ADDR_W-1:0]    araddr,
	input  logic                          arvalid,
	output logic                          arready,
	output logic [`LSI_AXI_DATA_W-1:0]    rdata,
	output logic [1:0]                    rresp,
	output logic                          rvalid,
	input  logic                          rready,
	output ctrl_t                         ctrl,
	output word_t                         dbi,
	output logic                          ce,
	output reg_idx_t                      sel,
	input  word_t                         reg_data,
	input  word_t                         src,
	input  word_t                         dst,
	input  word_t                         opcode,
	input  word_t                         alu_out,
	input  psw_t                          psw,
	input  logic                          taken
);

	rd_state_t rd_state;
	logic wr_go;
	logic rd_go;
	logic [`LSI_AXI_DATA_W-1:0] rd_mux;

	// ====================
	// write channel, one response outstanding
	assign wr_go = awvalid && wvalid && !bvalid;
	assign awready = wr_go;
	assign wready = wr_go;
	assign bresp = 2'b00;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			ctrl <= '0;
			dbi <= '0;
			ce <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			ce <= wr_go && (awaddr == `HR_STEP);	// lines up with bvalid rising
			if (wr_go) begin
				bvalid <= 1'b1;
				case (awaddr)
				`HR_CTRL: ctrl <= wdata;
				`HR_DBI: dbi <= wdata[`LSI_WORD_W-1:0];
				default: ;
				endcase
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// ====================
	// read channel
	assign rd_go = arvalid && (rd_state == RD_IDLE);
	assign arready = rd_go;
	assign rvalid = (rd_state == RD_VALID);
	assign rresp = 2'b00;
	assign sel = araddr[4:2];	// r0..r7 window index

	always_comb begin
		rd_mux = '0;
		if (araddr >= `HR_R0 && araddr <= `HR_R7) begin
			rd_mux[15:0] = reg_data;
		end else begin
			case (araddr)
			`HR_CTRL: rd_mux = ctrl;
			`HR_DBI: rd_mux[15:0] = dbi;
			`HR_STATUS: rd_mux[8:0] = {taken, psw};
			`HR_OPCODE: rd_mux[15:0] = opcode;
			`HR_SRC: rd_mux[15:0] = src;
			`HR_DST: rd_mux[15:0] = dst;
			`HR_ALUOUT: rd_mux[15:0] = alu_out;
			default: ;	// step and holes read zero
			endcase
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
			RD_IDLE: if (arvalid) rd_state <= RD_VALID;
			default: if (rready) rd_state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rd_go)
			rdata <= rd_mux;
	end

endmodule

//--- src/lsi_core_top.sv
// top level: host register block beside the stepped data path
`timescale 1ns/1ps
`include "lsi_cfg.svh"

module lsi_core_top
	import lsi_pkg::*;
(
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic [`LSI_AXI_ADDR_W-1:0]    awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [`LSI_AXI_DATA_W-1:0]    wdata,
	input  logic [`LSI_AXI_DATA_W/8-1:0]  wstrb,
	input  logic                          wvalid,
	output logic                          wready,
	output logic [1:0]                    bresp,
	output logic                          bvalid,
	input  logic                          bready,
	input  logic [`LSI_AXI_ADDR_W-1:0]    araddr,
	input  logic                          arvalid,
	output logic                          arready,
	output logic [`LSI_AXI_DATA_W-1:0]    rdata,
	output logic [1:0]                    rresp,
	output logic                          rvalid,
	input  logic                          rready
);

	ctrl_t ctrl;
	word_t dbi;
	logic ce;	// one-cycle step pulse
	reg_idx_t sel;
	word_t reg_data;
	word_t src;
	word_t dst;
	word_t opcode;
	word_t alu_out;
	psw_t psw;
	logic taken;

	lsi_host_regs u_host (
		.clk(clk),
		.reset_n(reset_n),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.ctrl(ctrl),
		.dbi(dbi),
		.ce(ce),
		.sel(sel),
		.reg_data(reg_data),
		.src(src),
		.dst(dst),
		.opcode(opcode),
		.alu_out(alu_out),
		.psw(psw),
		.taken(taken)
	);

	lsi_datapath u_dp (
		.clk(clk),
		.reset_n(reset_n),
		.ce(ce),
		.ctrl(ctrl),
		.dbi(dbi),
		.sel(sel),
		.reg_data(reg_data),
		.src(src),
		.dst(dst),
		.opcode(opcode),
		.alu_out(alu_out),
		.psw(psw),
		.taken(taken)
	);

endmodule

//--- tb/lsi_core_asserts.sv
// concurrent checks on the axi handshakes and the step enable, bound to the host block
`timescale 1ns/1ps

module lsi_core_asserts (
	input logic clk,
	input logic reset_n,
	input logic ce,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready
);

	int fails = 0;	// read by the testbench at the end

	ce_one_cycle: assert property (@(posedge clk) disable iff (!reset_n) ce |=> !ce)
		else begin
			$error("step enable stayed high for more than one cycle");
			fails++;
		end

	bvalid_hold: assert property (@(posedge clk) disable iff (!reset_n)
		bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			fails++;
		end

	rvalid_hold: assert property (@(posedge clk) disable iff (!reset_n)
		rvalid && !rready |=> rvalid)
		else begin
			$error("rvalid dropped before rready");
			fails++;
		end

	// step pulse lines up with the write response
	ce_with_bvalid: assert property (@(posedge clk) disable iff (!reset_n) ce |-> $rose(bvalid))
		else begin
			$error("step enable without a rising bvalid");
			fails++;
		end

endmodule

bind lsi_host_regs lsi_core_asserts u_asserts (
	.clk(clk),
	.reset_n(reset_n),
	.ce(ce),
	.bvalid(bvalid),
	.bready(bready),
	.rvalid(rvalid),
	.rready(rready)
);

//--- tb/lsi_core_tb.sv
// testbench: clock, reset, axi4-lite driver tasks, xorshift stimulus, reference model, checks
`timescale 1ns/1ps
`include "lsi_cfg.svh"

module lsi_core_tb
	import lsi_pkg::*;
();

	localparam int RESET_CYCLES = 10;
	localparam int N_LOAD = 16;
	localparam int N_WORD = 300;
	localparam int N_BYTE = 100;
	localparam int N_BR = 40;
	localparam int N_BP = 60;
	localparam int CHK_EVERY = 20;
	localparam int STEP_TXN = 4;	// ctrl, dbi, aluout read, step
	localparam int STATE_TXN = 12;
	localparam int TXN_TOTAL = 19 + N_LOAD * 2 * STEP_TXN + STATE_TXN
		+ (N_WORD + N_BYTE) * (STEP_TXN + 1) + (N_WORD + N_BYTE) / CHK_EVERY * STATE_TXN
		+ N_BR * (3 * STEP_TXN + 1) + STEP_TXN + 1
		+ N_BP * STEP_TXN + N_BP / CHK_EVERY * STATE_TXN;
	localparam int MAX_CYCLES = 200 * TXN_TOTAL + RESET_CYCLES;

	logic clk = 1'b0;
	logic reset_n;
	logic [7:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [7:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic [31:0] rng = 32'h9e37_cea7;
	logic stall_en = 1'b0;	// random bready/rready delays
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int steps = 0;

	// reference state
	word_t m_regs [8];
	word_t m_src;
	word_t m_dst;
	word_t m_opc;
	psw_t m_psw;

	lsi_core_top UUT (
		.clk(clk),
		.reset_n(reset_n),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	always #20 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic int rand_stall();
		logic [31:0] r;
		r = next_rand();
		return stall_en ? int'(r[2:0]) : 0;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// ====================
	// axi4-lite master
	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
		int stall;
		stall = rand_stall();
		@(posedge clk);
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do
			@(negedge clk);
		while (!(awready && wready));
		@(posedge clk);	// accept edge
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		do
			@(negedge clk);
		while (!bvalid);
		check_value("bresp", 32'h0, {30'd0, bresp});
		repeat (stall) @(posedge clk);
		@(posedge clk);
		bready <= 1'b1;
		@(posedge clk);	// response taken
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
		int stall;
		stall = rand_stall();
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		do
			@(negedge clk);
		while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		do
			@(negedge clk);
		while (!rvalid);
		data = rdata;
		check_value("rresp", 32'h0, {30'd0, rresp});
		repeat (stall) @(posedge clk);
		@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	// ====================
	// reference model
	// returns {result, n z v c, update mask}
	function automatic logic [23:0] model_alu(input word_t a, input word_t b, input alu_op_t op,
			input logic bm, input logic cin);
		logic [16:0] wm;
		logic [16:0] sb;	// sign bit of the operand width
		logic [16:0] x;
		logic [16:0] y;
		logic [16:0] t;
		logic [16:0] r;
		word_t res;
		logic xs;
		logic ys;
		logic n;
		logic z;
		logic v;
		logic c;
		flags_t mk;
		wm = bm ? 17'h000ff : 17'h0ffff;
		sb = bm ? 17'h00080 : 17'h08000;
		x = {1'b0, a} & wm;
		y = {1'b0, b} & wm;
		c = 1'b0;
		mk = 4'b1111;
		case (op)
		`OP_ADD: begin
			t = x + y;
			c = |(t & (sb << 1));
		end
		`OP_SUB, `OP_CMP: begin
			t = x - y;
			c = (x < y);	// borrow
		end
		`OP_INC: begin
			t = x + 17'd1;
			mk = 4'b1110;
		end
		`OP_DEC: begin
			t = x - 17'd1;
			mk = 4'b1110;
		end
		`OP_COM: begin
			t = ~x;
			c = 1'b1;
		end
		`OP_NEG: begin
			t = 17'd0 - x;
			c = ((t & wm) != 17'd0);
		end
		`OP_ASL, `OP_ROL: begin
			t = (x << 1) | ((op == `OP_ROL) ? {16'd0, cin} : 17'd0);
			c = |(x & sb);
		end
		`OP_ASR, `OP_ROR: begin
			t = (x >> 1) | ((op == `OP_ROR) ? (cin ? sb : 17'd0) : (x & sb));
			c = x[0];
		end
		`OP_MOV: t = y;
		`OP_BIC: t = x & ~y;
		`OP_BIS: t = x | y;
		`OP_XOR: t = x ^ y;
		default: t = 17'd0;	// swab below
		endcase
		if (op == `OP_MOV || op == `OP_BIC || op == `OP_BIS || op == `OP_XOR)
			mk = 4'b1110;
		r = t & wm;
		xs = |(x & sb);
		ys = |(y & sb);
		n = |(r & sb);
		z = (r == 17'd0);
		case (op)
		`OP_ADD: v = (xs == ys) && (n != xs);
		`OP_SUB, `OP_CMP: v = (xs != ys) && (n != xs);
		`OP_INC, `OP_NEG: v = (r == sb);
		`OP_DEC: v = (x == sb);
		`OP_ASL, `OP_ASR, `OP_ROL, `OP_ROR: v = n ^ c;
		default: v = 1'b0;
		endcase
		if (op == `OP_SWAB) begin
			res = {a[7:0], a[15:8]};
			n = a[15];
			z = (a[15:8] == 8'h00);
			c = 1'b0;
		end else if (op == `OP_CMP) begin
			res = a;
		end else begin
			res = bm ? {a[15:8], r[7:0]} : r[15:0];
		end
		return {res, n, z, v, c, mk};
	endfunction

	function automatic logic [23:0] model_out(input ctrl_t cw);
		word_t a;
		word_t b;
		case (cw[`CW_A_SEL])
		3'd0: a = m_regs[cw[`CW_RA]];
		3'd1: a = m_src;
		3'd2: a = m_dst;
		3'd3: a = m_regs[7];
		3'd4: a = {8'h00, m_psw};
		default: a = '0;
		endcase
		case (cw[`CW_B_SEL])
		2'd0: b = m_src;
		2'd1: b = m_dst;
		2'd2: b = '0;
		default: b = 16'($signed(m_opc[7:0])) << 1;	// offset in bytes
		endcase
		return model_alu(a, b, cw[`CW_OP], cw[`CW_BYTE], m_psw[0]);
	endfunction

	// table rows: always, z, n^v, (n^v)|z, n, c|z, v, c
	function automatic logic branch_taken(input word_t opc, input flags_t f);
		logic hit;
		case ({opc[15], opc[10:9]})
		3'd1: hit = f[2];
		3'd2: hit = f[3] ^ f[1];
		3'd3: hit = (f[3] ^ f[1]) | f[2];
		3'd4: hit = f[3];
		3'd5: hit = f[0] | f[2];
		3'd6: hit = f[1];
		3'd7: hit = f[0];
		default: hit = 1'b1;
		endcase
		return opc[8] ? hit : !hit;
	endfunction

	task automatic apply_step(input ctrl_t cw, input word_t d);
		logic [23:0] r;
		r = model_out(cw);
		if (cw[`CW_UPD_CC] && cw[`CW_DST_PSW]) begin
			m_psw = m_dst[7:0];
		end else if (cw[`CW_UPD_CC]) begin
			for (int i = 0; i < 4; i++)
				if (r[i])
					m_psw[i] = r[4 + i];
		end
		if (cw[`CW_WR_REG])
			m_regs[cw[`CW_RD]] = r[23:8];
		if (cw[`CW_PC_ROM])
			m_regs[7] = 16'o100000;
		if (cw[`CW_DBI_SRC])
			m_src = d;
		else if (cw[`CW_WR_SRC])
			m_src = r[23:8];
		if (cw[`CW_WR_DST])
			m_dst = r[23:8];
		if (cw[`CW_SET_OPC])
			m_opc = d;
		steps++;
	endtask

	// ====================
	// stimulus helpers
	function automatic ctrl_t rand_ctrl(input logic byte_ok);
		logic [31:0] r;
		ctrl_t cw;
		r = next_rand();
		cw = r & 32'h001f_ffff;	// up to byte mode
		cw[`CW_A_SEL] = r[6:4] % 3'd5;
		if (!byte_ok)
			cw[`CW_BYTE] = 1'b0;
		return cw;
	endfunction

	task automatic run_step(input string name, input ctrl_t cw, input word_t d);
		logic [31:0] got;
		logic [23:0] r;
		axi_write(`HR_CTRL, cw);
		axi_write(`HR_DBI, {16'h0000, d});
		r = model_out(cw);
		axi_read(`HR_ALUOUT, got);
		check_value({name, " aluout"}, {16'h0000, r[23:8]}, got);
		axi_write(`HR_STEP, 32'h0);
		apply_step(cw, d);
	endtask

	task automatic read_status(input string name);
		logic [31:0] got;
		axi_read(`HR_STATUS, got);
		check_value({name, " status"}, {23'd0, branch_taken(m_opc, m_psw[3:0]), m_psw}, got);
	endtask

	task automatic check_state(input string name);
		logic [31:0] got;
		read_status(name);
		axi_read(`HR_OPCODE, got);
		check_value({name, " opcode"}, {16'h0000, m_opc}, got);
		axi_read(`HR_SRC, got);
		check_value({name, " src"}, {16'h0000, m_src}, got);
		axi_read(`HR_DST, got);
		check_value({name, " dst"}, {16'h0000, m_dst}, got);
		for (int i = 0; i < 8; i++) begin
			axi_read(8'(`HR_R0 + 4 * i), got);
			check_value($sformatf("%s r%0d", name, i), {16'h0000, m_regs[i]}, got);
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] got;
		ctrl_t cw;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wstrb <= 4'hf;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		reset_n <= 1'b0;
		for (int i = 0; i < 8; i++)
			m_regs[i] = '0;
		m_src = '0;
		m_dst = '0;
		m_opc = '0;
		m_psw = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_n <= 1'b1;

		// ==================== reset values and readback
		axi_read(`HR_CTRL, got);
		check_value("reset ctrl", 32'h0, got);
		axi_read(`HR_DBI, got);
		check_value("reset dbi", 32'h0, got);
		axi_read(`HR_ALUOUT, got);
		check_value("reset aluout", 32'h0, got);
		check_state("reset");
		r = next_rand();
		axi_write(`HR_CTRL, r);
		axi_read(`HR_CTRL, got);
		check_value("ctrl readback", r, got);
		r = next_rand();
		axi_write(`HR_DBI, r);
		axi_read(`HR_DBI, got);
		check_value("dbi readback", {16'h0000, r[15:0]}, got);

		// ==================== operand loads
		for (int k = 0; k < N_LOAD; k++) begin
			r = next_rand();
			cw = '0;
			cw[`CW_DBI_SRC] = 1'b1;
			cw[`CW_SET_OPC] = 1'b1;
			run_step("load", cw, r[15:0]);
			cw = '0;
			cw[`CW_OP] = `OP_MOV;	// b_sel 0 picks src
			cw[`CW_RD] = r[18:16];
			cw[`CW_WR_REG] = 1'b1;
			run_step("load mov", cw, r[31:16]);
		end
		check_state("load");

		// ==================== word alu
		for (int k = 0; k < N_WORD; k++) begin
			r = next_rand();
			run_step("word alu", rand_ctrl(1'b0), r[15:0]);
			read_status("word alu");
			if (k % CHK_EVERY == CHK_EVERY - 1)
				check_state("word alu");
		end

		// ==================== byte mode and shifts
		for (int k = 0; k < N_BYTE; k++) begin
			r = next_rand();
			cw = rand_ctrl(1'b1);
			cw[`CW_BYTE] = r[0] | r[1];
			cw[`CW_UPD_CC] = 1'b1;	// keeps c moving for the rotates
			if (r[31]) begin
				case (r[30:28] % 3'd5)
				3'd0: cw[`CW_OP] = `OP_ASL;
				3'd1: cw[`CW_OP] = `OP_ASR;
				3'd2: cw[`CW_OP] = `OP_ROL;
				3'd3: cw[`CW_OP] = `OP_ROR;
				default: cw[`CW_OP] = `OP_SWAB;
				endcase
			end
			run_step("byte/shift", cw, r[15:0]);
			read_status("byte/shift");
			if (k % CHK_EVERY == CHK_EVERY - 1)
				check_state("byte/shift");
		end

		// ==================== branch condition
		for (int k = 0; k < N_BR; k++) begin
			r = next_rand();
			cw = '0;
			cw[`CW_DBI_SRC] = 1'b1;
			run_step("branch src", cw, r[15:0]);
			cw = '0;
			cw[`CW_OP] = `OP_MOV;
			cw[`CW_WR_DST] = 1'b1;
			run_step("branch dst", cw, r[15:0]);
			cw = '0;
			cw[`CW_UPD_CC] = 1'b1;
			cw[`CW_DST_PSW] = 1'b1;
			cw[`CW_SET_OPC] = 1'b1;
			run_step("branch psw", cw, r[31:16]);
			read_status("branch");
		end
		cw = '0;
		cw[`CW_PC_ROM] = 1'b1;
		cw[`CW_WR_REG] = 1'b1;
		cw[`CW_RD] = 3'd7;	// loses against the rom load
		run_step("rom start", cw, 16'h0000);
		axi_read(`HR_R7, got);
		check_value("rom start pc", {16'h0000, 16'o100000}, got);

		// ==================== back-pressure
		stall_en = 1'b1;
		for (int k = 0; k < N_BP; k++) begin
			r = next_rand();
			cw = rand_ctrl(1'b1);
			cw[`CW_SET_OPC] = r[21];
			cw[`CW_PC_ROM] = r[23] & r[24];
			run_step("backpressure", cw, r[31:16]);
			if (k % CHK_EVERY == CHK_EVERY - 1)
				check_state("backpressure");
		end

		$display("steps %0d, checks %0d, errors %0d, assertion failures %0d",
			steps, checks, errors, UUT.u_host.u_asserts.fails);
		if (errors == 0 && UUT.u_host.u_asserts.fails == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- sim.f
+incdir+common
common/lsi_pkg.sv
datapath/lsi_alu.sv
datapath/lsi_datapath.sv
src/lsi_host_regs.sv
src/lsi_core_top.sv
tb/lsi_core_asserts.sv
tb/lsi_core_tb.sv

//--- run_sim.sh
#!/bin/bash
# build with Verilator, run, and decide pass or fail from the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps --top-module lsi_core_tb -f sim.f
./obj_dir/Vlsi_core_tb +verilator+error+limit+1000 | tee sim.log
if grep -q "^TEST OK$" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
